//--- source/block_fifo.sv
// Single-clock FWFT FIFO. A push when full is dropped and a pop when empty is ignored
`default_nettype none
`include "ramtest_cfg.svh"

module block_fifo #(
	parameter int depth = `RT_FIFO_DEPTH
) (
	input  logic                     okClk,
	input  logic                     rst_n,
	input  logic                     clear,
	input  logic                     push,
	input  logic                     pop,
	input  ramtest_pkg::word_t       push_data,
	output ramtest_pkg::word_t       head_data,
	output ramtest_pkg::fifo_count_t count,
	output logic                     empty,
	output logic                     full
);
	import ramtest_pkg::*;

	localparam int ptr_w = $clog2(depth);

	word_t            mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic             do_push;
	logic             do_pop;

	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
		if (ptr == ptr_w'(depth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign full = (count == fifo_count_t'(depth));
	assign do_push = push && !full;
	assign do_pop = pop && !empty;
	assign head_data = mem[rd_ptr]; // Head word without a pop

	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	// Storage
	always_ff @(posedge okClk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

endmodule

`default_nettype wire

//--- source/burst_ram.sv
// Behavioral memory model. Contents are undefined until written and are kept across soft reset
`default_nettype none
`include "ramtest_cfg.svh"

module burst_ram (
	input  logic                   okClk,
	input  logic                   rst_n,
	input  logic                   mem_cmd_en,
	input  logic                   mem_cmd_write,
	input  ramtest_pkg::mem_addr_t mem_cmd_addr,
	input  logic                   mem_wr_en,
	input  ramtest_pkg::word_t     mem_wr_data,
	output logic                   mem_busy,
	output logic                   mem_rd_valid,
	output logic                   calib_done,
	output ramtest_pkg::word_t     mem_rd_data
);
	import ramtest_pkg::*;

	localparam int lat_stages = `RT_RD_LATENCY - 1; // Array read takes the first cycle
	localparam int left_w = $clog2(`RT_BURST_LEN + 1);
	localparam int calib_w = $clog2(`RT_CALIB_CYCLES + 1);

	word_t                 mem [`RT_MEM_WORDS];
	logic [calib_w-1:0]    calib_cnt;
	logic [left_w-1:0]     beats_left;
	logic                  burst_write;
	mem_addr_t             burst_addr;
	logic                  accept;
	logic                  rd_issue;
	logic [lat_stages-1:0] pipe_valid;
	word_t                 pipe_data [lat_stages];

	assign accept = mem_cmd_en && !mem_busy;
	assign rd_issue = (beats_left != '0) && !burst_write;
	assign mem_busy = !calib_done || (beats_left != '0) || (|pipe_valid); // Until last read word
	assign mem_rd_valid = pipe_valid[lat_stages-1];
	assign mem_rd_data = pipe_data[lat_stages-1];

	// Calibration delay
	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			calib_cnt <= '0;
			calib_done <= 1'b0;
		end else if (!calib_done) begin
			calib_cnt <= calib_cnt + 1'b1;
			calib_done <= (calib_cnt == calib_w'(`RT_CALIB_CYCLES - 1));
		end
	end

	// ------------------------------------------------------------
	// Burst sequencing and read delay line
	// ------------------------------------------------------------
	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			beats_left <= '0;
			burst_write <= 1'b0;
			burst_addr <= '0;
			pipe_valid <= '0;
		end else begin
			if (accept) begin
				beats_left <= left_w'(`RT_BURST_LEN);
				burst_write <= mem_cmd_write;
				burst_addr <= mem_cmd_addr;
			end else if (beats_left != '0) begin
				beats_left <= beats_left - 1'b1;
				burst_addr <= burst_addr + 1'b1; // Wraps at memory end
			end
			pipe_valid[0] <= rd_issue;
			for (int i = 1; i < lat_stages; i++)
				pipe_valid[i] <= pipe_valid[i-1];
		end
	end

	// Write window is fixed so a cut-short burst still ends on time
	always_ff @(posedge okClk) begin
		if (burst_write && beats_left != '0 && mem_wr_en)
			mem[burst_addr] <= mem_wr_data;
		pipe_data[0] <= mem[burst_addr];
		for (int i = 1; i < lat_stages; i++)
			pipe_data[i] <= pipe_data[i-1];
	end

endmodule

`default_nettype wire

//--- source/dma_engine.sv
// One burst in flight at a time. Reads are not ordered against writes so RD_ADDR may pass WR_ADDR
`default_nettype none
`include "ramtest_cfg.svh"

module dma_engine (
	input  logic                     okClk,
	input  logic                     rst_n,
	input  logic                     soft_rst,
	input  logic                     read_en,
	input  logic                     write_en,
	input  logic                     calib_done,
	output logic                     in_pop,
	input  ramtest_pkg::word_t       in_data,
	input  ramtest_pkg::fifo_count_t in_count,
	input  ramtest_pkg::fifo_count_t out_count,
	output logic                     out_push,
	output ramtest_pkg::word_t       out_data,
	output logic                     mem_cmd_en,
	output logic                     mem_cmd_write,
	output ramtest_pkg::mem_addr_t   mem_cmd_addr,
	input  logic                     mem_busy,
	output logic                     mem_wr_en,
	output ramtest_pkg::word_t       mem_wr_data,
	input  logic                     mem_rd_valid,
	input  ramtest_pkg::word_t       mem_rd_data,
	output ramtest_pkg::mem_addr_t   wr_addr,
	output ramtest_pkg::mem_addr_t   rd_addr
);
	import ramtest_pkg::*;

	localparam int beat_w = $clog2(`RT_BURST_LEN);
	localparam logic [beat_w-1:0] last_beat = beat_w'(`RT_BURST_LEN - 1);
	localparam fifo_count_t burst_count = fifo_count_t'(`RT_BURST_LEN);
	localparam fifo_count_t out_max = fifo_count_t'(`RT_FIFO_DEPTH - `RT_BURST_LEN);

	dma_state_t        state;
	logic [beat_w-1:0] beat;
	logic              write_turn; // Write wins the next tie
	logic              wr_ok;
	logic              rd_ok;

	assign wr_ok = write_en && (in_count >= burst_count);
	assign rd_ok = read_en && (out_count <= out_max); // Room for a full burst

	// ------------------------------------------------------------
	// Memory port and FIFO strobes
	// ------------------------------------------------------------
	assign mem_cmd_en = (state == dma_write_cmd) || (state == dma_read_cmd);
	assign mem_cmd_write = (state == dma_write_cmd);
	assign mem_cmd_addr = mem_cmd_write ? wr_addr : rd_addr;
	assign mem_wr_en = (state == dma_write_data);
	assign mem_wr_data = in_data; // Straight from the FIFO head
	assign in_pop = mem_wr_en;
	assign out_push = (state == dma_read_wait) && mem_rd_valid;
	assign out_data = mem_rd_data;

	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			state <= dma_idle;
			beat <= '0;
			write_turn <= 1'b1;
			wr_addr <= '0;
			rd_addr <= '0;
		end else if (soft_rst) begin
			state <= dma_idle;
			beat <= '0;
			write_turn <= 1'b1;
			wr_addr <= '0;
			rd_addr <= '0;
		end else begin
			case (state)
				dma_idle: begin
					beat <= '0;
					if (calib_done) begin
						if (wr_ok && (write_turn || !rd_ok)) begin
							state <= dma_write_cmd;
							write_turn <= 1'b0;
						end else if (rd_ok) begin
							state <= dma_read_cmd;
							write_turn <= 1'b1;
						end
					end
				end
				dma_write_cmd: begin
					if (!mem_busy)
						state <= dma_write_data;
				end
				dma_write_data: begin
					beat <= beat + 1'b1;
					if (beat == last_beat) begin
						state <= dma_idle;
						wr_addr <= wr_addr + mem_addr_t'(`RT_BURST_LEN); // Wraps with width
					end
				end
				dma_read_cmd: begin
					if (!mem_busy)
						state <= dma_read_wait;
				end
				dma_read_wait: begin
					if (mem_rd_valid) begin
						beat <= beat + 1'b1;
						if (beat == last_beat) begin
							state <= dma_idle;
							rd_addr <= rd_addr + mem_addr_t'(`RT_BURST_LEN);
						end
					end
				end
				default: state <= dma_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/host_regs.sv
// Wishbone classic slave with one wait state. CTRL bits are levels and never self-clear
`default_nettype none
`include "ramtest_cfg.svh"

module host_regs (
	input  logic                     okClk,
	input  logic                     rst_n,
	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic                     wb_we,
	input  ramtest_pkg::reg_addr_t   wb_adr,
	input  ramtest_pkg::word_t       wb_dat_w,
	output ramtest_pkg::word_t       wb_dat_r,
	output logic                     wb_ack,
	input  logic                     calib_done,
	input  logic                     in_empty,
	input  logic                     in_full,
	input  logic                     out_empty,
	input  logic                     out_full,
	input  ramtest_pkg::fifo_count_t in_count,
	input  ramtest_pkg::fifo_count_t out_count,
	input  ramtest_pkg::mem_addr_t   wr_addr,
	input  ramtest_pkg::mem_addr_t   rd_addr,
	output logic                     read_en,
	output logic                     write_en,
	output logic                     soft_rst,
	output logic                     pipe_in_ready,
	output logic                     pipe_out_ready
);
	import ramtest_pkg::*;

	// ------------------------------------------------------------
	// Register map
	//   0 CTRL     bit 0 read enable, bit 1 write enable, bit 2 soft reset
	//   1 STATUS   bit 0 calib done, 1 in empty, 2 in full, 3 out empty, 4 out full
	//   2 WR_ADDR  next memory write address
	//   3 RD_ADDR  next memory read address
	// ------------------------------------------------------------
	localparam reg_addr_t addr_ctrl = 2'd0;
	localparam reg_addr_t addr_status = 2'd1;
	localparam reg_addr_t addr_wr_addr = 2'd2;
	localparam reg_addr_t addr_rd_addr = 2'd3;

	localparam fifo_count_t in_ready_max =
		fifo_count_t'(`RT_FIFO_DEPTH - `RT_HEADROOM - `RT_BLOCK_SIZE);
	localparam fifo_count_t out_ready_min = fifo_count_t'(`RT_BLOCK_SIZE);

	logic [2:0] ctrl;
	logic       access;
	word_t      rd_mux;

	assign access = wb_cyc && wb_stb && !wb_ack; // New cycle not yet acked
	assign read_en = ctrl[0];
	assign write_en = ctrl[1];
	assign soft_rst = ctrl[2];

	always_comb begin
		case (wb_adr)
			addr_ctrl:    rd_mux = {29'd0, ctrl};
			addr_status:  rd_mux = {27'd0, out_full, out_empty, in_full, in_empty, calib_done};
			addr_wr_addr: rd_mux = word_t'(wr_addr);
			addr_rd_addr: rd_mux = word_t'(rd_addr);
			default:      rd_mux = '0;
		endcase
	end

	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			ctrl <= '0;
		end else begin
			wb_ack <= access;
			if (access && wb_we && wb_adr == addr_ctrl)
				ctrl <= wb_dat_w[2:0]; // Lands with ack
		end
	end

	// Read data valid with ack
	always_ff @(posedge okClk) begin
		if (access)
			wb_dat_r <= rd_mux;
	end

	// ------------------------------------------------------------
	// Block throttle
	// ------------------------------------------------------------
	always_ff @(posedge okClk or negedge rst_n) begin
		if (!rst_n) begin
			pipe_in_ready <= 1'b1;
			pipe_out_ready <= 1'b0;
		end else begin
			pipe_in_ready <= (in_count <= in_ready_max);   // Whole block plus headroom
			pipe_out_ready <= (out_count >= out_ready_min); // Whole block waiting
		end
	end

endmodule

`default_nettype wire

//--- source/ramtest_cfg.svh
// Build-time sizes. RT_MEM_WORDS must be a power of two and RT_RD_LATENCY at least 2
`ifndef RAMTEST_CFG_SVH
`define RAMTEST_CFG_SVH

// ------------------------------------------------------------
// Host block framing
// ------------------------------------------------------------
`define RT_BLOCK_SIZE   16   // Words per host block
`define RT_FIFO_DEPTH   64   // Words per pipe FIFO
`define RT_HEADROOM     4    // Throttle margin in words

// ------------------------------------------------------------
// Memory model
// ------------------------------------------------------------
`define RT_BURST_LEN    8    // Words per command
`define RT_MEM_WORDS    1024 // Addresses wrap here
`define RT_CALIB_CYCLES 32
`define RT_RD_LATENCY   3    // Command accept to first read word

`endif

//--- source/ramtest_pkg.sv
// Shared types. Address and count widths follow the config macros at elaboration
`default_nettype none
`include "ramtest_cfg.svh"

package ramtest_pkg;

	// Data path
	typedef logic [31:0] word_t;

	// Word address into the burst memory
	typedef logic [$clog2(`RT_MEM_WORDS)-1:0] mem_addr_t;

	// FIFO occupancy including the full value
	typedef logic [$clog2(`RT_FIFO_DEPTH + 1)-1:0] fifo_count_t;

	// Wishbone word address
	typedef logic [1:0] reg_addr_t;

	// ------------------------------------------------------------
	// DMA burst sequencing
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		dma_idle,
		dma_write_cmd,  // Waiting for memory to take a write
		dma_write_data,
		dma_read_cmd,   // Waiting for memory to take a read
		dma_read_wait
	} dma_state_t;

endpackage

`default_nettype wire

//--- source/ramtest_top.sv
// Single clock domain on okClk. Soft reset clears the FIFOs and DMA but keeps memory contents
`default_nettype none
`include "ramtest_cfg.svh"

module ramtest_top (
	input  logic                   okClk,
	input  logic                   rst_n,
	input  logic                   wb_cyc,
	input  logic                   wb_stb,
	input  logic                   wb_we,
	input  ramtest_pkg::reg_addr_t wb_adr,
	input  ramtest_pkg::word_t     wb_dat_w,
	output ramtest_pkg::word_t     wb_dat_r,
	output logic                   wb_ack,
	input  logic                   pipe_in_write,
	input  ramtest_pkg::word_t     pipe_in_data,
	output logic                   pipe_in_ready,
	input  logic                   pipe_out_read,
	output ramtest_pkg::word_t     pipe_out_data,
	output logic                   pipe_out_ready
);
	import ramtest_pkg::*;

	// Control
	logic        read_en;
	logic        write_en;
	logic        soft_rst;
	logic        calib_done;

	// Pipe FIFOs
	logic        in_pop;
	word_t       in_data;
	fifo_count_t in_count;
	logic        in_empty;
	logic        in_full;
	logic        out_push;
	word_t       out_data;
	fifo_count_t out_count;
	logic        out_empty;
	logic        out_full;

	// Memory port
	logic        mem_cmd_en;
	logic        mem_cmd_write;
	mem_addr_t   mem_cmd_addr;
	logic        mem_busy;
	logic        mem_wr_en;
	word_t       mem_wr_data;
	logic        mem_rd_valid;
	word_t       mem_rd_data;
	mem_addr_t   wr_addr;
	mem_addr_t   rd_addr;

	host_regs u_regs (
		.okClk          (okClk),
		.rst_n          (rst_n),
		.wb_cyc         (wb_cyc),
		.wb_stb         (wb_stb),
		.wb_we          (wb_we),
		.wb_adr         (wb_adr),
		.wb_dat_w       (wb_dat_w),
		.wb_dat_r       (wb_dat_r),
		.wb_ack         (wb_ack),
		.calib_done     (calib_done),
		.in_empty       (in_empty),
		.in_full        (in_full),
		.out_empty      (out_empty),
		.out_full       (out_full),
		.in_count       (in_count),
		.out_count      (out_count),
		.wr_addr        (wr_addr),
		.rd_addr        (rd_addr),
		.read_en        (read_en),
		.write_en       (write_en),
		.soft_rst       (soft_rst),
		.pipe_in_ready  (pipe_in_ready),
		.pipe_out_ready (pipe_out_ready)
	);

	// Host to DMA
	block_fifo #(.depth(`RT_FIFO_DEPTH)) u_in_fifo (
		.okClk     (okClk),
		.rst_n     (rst_n),
		.clear     (soft_rst),
		.push      (pipe_in_write),
		.pop       (in_pop),
		.push_data (pipe_in_data),
		.head_data (in_data),
		.count     (in_count),
		.empty     (in_empty),
		.full      (in_full)
	);

	// DMA to host
	block_fifo #(.depth(`RT_FIFO_DEPTH)) u_out_fifo (
		.okClk     (okClk),
		.rst_n     (rst_n),
		.clear     (soft_rst),
		.push      (out_push),
		.pop       (pipe_out_read),
		.push_data (out_data),
		.head_data (pipe_out_data),
		.count     (out_count),
		.empty     (out_empty),
		.full      (out_full)
	);

	dma_engine u_dma (
		.okClk         (okClk),
		.rst_n         (rst_n),
		.soft_rst      (soft_rst),
		.read_en       (read_en),
		.write_en      (write_en),
		.calib_done    (calib_done),
		.in_pop        (in_pop),
		.in_data       (in_data),
		.in_count      (in_count),
		.out_count     (out_count),
		.out_push      (out_push),
		.out_data      (out_data),
		.mem_cmd_en    (mem_cmd_en),
		.mem_cmd_write (mem_cmd_write),
		.mem_cmd_addr  (mem_cmd_addr),
		.mem_busy      (mem_busy),
		.mem_wr_en     (mem_wr_en),
		.mem_wr_data   (mem_wr_data),
		.mem_rd_valid  (mem_rd_valid),
		.mem_rd_data   (mem_rd_data),
		.wr_addr       (wr_addr),
		.rd_addr       (rd_addr)
	);

	burst_ram u_mem (
		.okClk         (okClk),
		.rst_n         (rst_n),
		.mem_cmd_en    (mem_cmd_en),
		.mem_cmd_write (mem_cmd_write),
		.mem_cmd_addr  (mem_cmd_addr),
		.mem_wr_en     (mem_wr_en),
		.mem_wr_data   (mem_wr_data),
		.mem_busy      (mem_busy),
		.mem_rd_valid  (mem_rd_valid),
		.calib_done    (calib_done),
		.mem_rd_data   (mem_rd_data)
	);

endmodule

`default_nettype wire

//--- tb.f
+incdir+source
+incdir+tests
source/ramtest_pkg.sv
source/block_fifo.sv
source/host_regs.sv
source/dma_engine.sv
source/burst_ram.sv
source/ramtest_top.sv
tests/tb_ramtest.sv

//--- tests/tb_ramtest_tasks.svh
// Included inside tb_ramtest only. Relies on its bus signals, scoreboard and generator state
`ifndef TB_RAMTEST_TASKS_SVH
`define TB_RAMTEST_TASKS_SVH

// Next value of the stimulus generator
function automatic word_t lcg_next(input word_t state);
	return state * 32'd1664525 + 32'd1013904223;
endfunction

// ------------------------------------------------------------
// Wishbone classic, one access at a time
// ------------------------------------------------------------
task automatic write_reg(input reg_addr_t adr, input word_t data);
	@(posedge okClk);
	wb_cyc <= 1'b1;
	wb_stb <= 1'b1;
	wb_we <= 1'b1;
	wb_adr <= adr;
	wb_dat_w <= data;
	@(posedge okClk);
	while (!wb_ack)
		@(posedge okClk);
	wb_cyc <= 1'b0;
	wb_stb <= 1'b0;
	wb_we <= 1'b0;
endtask

task automatic read_reg(input reg_addr_t adr, output word_t data);
	@(posedge okClk);
	wb_cyc <= 1'b1;
	wb_stb <= 1'b1;
	wb_we <= 1'b0;
	wb_adr <= adr;
	@(posedge okClk);
	while (!wb_ack)
		@(posedge okClk);
	data = wb_dat_r; // Valid with ack
	wb_cyc <= 1'b0;
	wb_stb <= 1'b0;
endtask

// ------------------------------------------------------------
// Pipe blocks
// ------------------------------------------------------------
task automatic push_block();
	word_t data;
	repeat (2) @(posedge okClk); // Registered ready lags the count
	while (!pipe_in_ready)
		@(posedge okClk);
	pipe_in_write <= 1'b1;
	for (int i = 0; i < `RT_BLOCK_SIZE; i++) begin
		lcg_state = lcg_next(lcg_state);
		data = lcg_state;
		scoreboard.push_back(data);
		pipe_in_data <= data;
		@(posedge okClk);
	end
	pipe_in_write <= 1'b0;
endtask

task automatic pull_block();
	word_t expected;
	repeat (2) @(posedge okClk);
	while (!pipe_out_ready)
		@(posedge okClk);
	pipe_out_read <= 1'b1;
	for (int i = 0; i < `RT_BLOCK_SIZE; i++) begin
		@(posedge okClk); // Head seen here is the word popped at this edge
		if (scoreboard.size() == 0) begin
			report_problem("pipe read returned more words than were pushed");
		end else begin
			expected = scoreboard.pop_front();
			if (pipe_out_data !== expected)
				report_mismatch("pipe_out_data", pipe_out_data, expected);
		end
	end
	pipe_out_read <= 1'b0;
endtask

`endif

//--- tests/tb_ramtest.sv
// Single okClk domain. Expects empty memory at start and a table whose rows depend on earlier rows
`default_nettype none
`include "ramtest_cfg.svh"

module tb_ramtest;
	timeunit 1ns;
	timeprecision 1ps;
	import ramtest_pkg::*;

	// Register map as seen by the host
	localparam reg_addr_t reg_ctrl = 2'd0;
	localparam reg_addr_t reg_status = 2'd1;
	localparam reg_addr_t reg_wr_addr = 2'd2;
	localparam reg_addr_t reg_rd_addr = 2'd3;
	localparam word_t ctrl_read = 32'h1;
	localparam word_t ctrl_write = 32'h2;
	localparam word_t ctrl_soft = 32'h4;
	localparam int status_in_empty = 1;
	localparam int status_out_full = 4;

	// Operation codes
	localparam int op_idle = 0;
	localparam int op_write = 1;
	localparam int op_fill = 2;
	localparam int op_read = 3;
	localparam int op_wrap = 4;
	localparam int op_soft = 5;
	localparam int n_tests = 6;

	// ------------------------------------------------------------
	// Test table, applied in order
	// ------------------------------------------------------------
	int    op_tab     [n_tests] = '{op_idle, op_write, op_fill, op_read, op_wrap, op_soft};
	int    blocks_tab [n_tests] = '{0, 4, 3, 4, 3, 0};
	word_t expect_tab [n_tests] = '{
		32'h0000_000b, // STATUS with calib done, both FIFOs empty
		32'd64,        // WR_ADDR after 4 blocks
		32'd112,       // WR_ADDR after 3 more
		32'd128,       // RD_ADDR, 64 pulled plus 64 buffered
		32'd176,       // RD_ADDR, 112 pulled plus 64 buffered
		32'h0000_000b  // STATUS after soft reset
	};

	logic      okClk = 1'b0;
	logic      rst_n;
	logic      wb_cyc;
	logic      wb_stb;
	logic      wb_we;
	reg_addr_t wb_adr;
	word_t     wb_dat_w;
	word_t     wb_dat_r;
	logic      wb_ack;
	logic      pipe_in_write;
	word_t     pipe_in_data;
	logic      pipe_in_ready;
	logic      pipe_out_read;
	word_t     pipe_out_data;
	logic      pipe_out_ready;

	word_t     scoreboard [$]; // Words pushed, not yet read back
	word_t     lcg_state;
	int        test_errors;
	int        error_total;
	int        tests_passed;
	int        tests_failed;
	int        cycle_count;
	int        cycle_limit;

	ramtest_top u_dut (
		.okClk          (okClk),
		.rst_n          (rst_n),
		.wb_cyc         (wb_cyc),
		.wb_stb         (wb_stb),
		.wb_we          (wb_we),
		.wb_adr         (wb_adr),
		.wb_dat_w       (wb_dat_w),
		.wb_dat_r       (wb_dat_r),
		.wb_ack         (wb_ack),
		.pipe_in_write  (pipe_in_write),
		.pipe_in_data   (pipe_in_data),
		.pipe_in_ready  (pipe_in_ready),
		.pipe_out_read  (pipe_out_read),
		.pipe_out_data  (pipe_out_data),
		.pipe_out_ready (pipe_out_ready)
	);

	always #20 okClk = ~okClk; // 40 ns period

	task automatic report_mismatch(input string sig_name, input word_t got, input word_t exp);
		$display("FAIL t=%0t %s got 0x%08h expected 0x%08h", $time, sig_name, got, exp);
		test_errors++;
	endtask

	task automatic report_problem(input string what);
		$display("ERROR t=%0t %s", $time, what);
		test_errors++;
	endtask

	`include "tb_ramtest_tasks.svh"

	function automatic string op_name(input int op);
		case (op)
			op_idle:  return "idle_status";
			op_write: return "write_blocks";
			op_fill:  return "input_throttle";
			op_read:  return "read_blocks";
			op_wrap:  return "read_past_write";
			op_soft:  return "soft_reset";
			default:  return "unknown";
		endcase
	endfunction

	// 200 cycles per block plus fixed margin
	function automatic int table_limit();
		int total;
		total = 2000;
		for (int t = 0; t < n_tests; t++)
			total += 200 * blocks_tab[t];
		return total;
	endfunction

	task automatic wait_status(input int bit_idx);
		word_t value;
		value = '0;
		while (value[bit_idx] !== 1'b1)
			read_reg(reg_status, value);
	endtask

	task automatic check_idle(input word_t exp);
		word_t value;
		read_reg(reg_status, value);
		if (value !== exp)
			report_mismatch("STATUS", value, exp);
		read_reg(reg_wr_addr, value);
		if (value !== 32'd0)
			report_mismatch("WR_ADDR", value, 32'd0);
		read_reg(reg_rd_addr, value);
		if (value !== 32'd0)
			report_mismatch("RD_ADDR", value, 32'd0);
		if (pipe_in_ready !== 1'b1)
			report_mismatch("pipe_in_ready", word_t'(pipe_in_ready), 32'd1);
		if (pipe_out_ready !== 1'b0)
			report_mismatch("pipe_out_ready", word_t'(pipe_out_ready), 32'd0);
	endtask

	// ------------------------------------------------------------
	// One table row
	// ------------------------------------------------------------
	task automatic run_test(input int op, input int blocks, input word_t exp);
		word_t value;
		word_t other;
		case (op)
			op_idle: begin
				repeat (`RT_CALIB_CYCLES) @(posedge okClk);
				check_idle(exp);
			end
			op_write: begin
				write_reg(reg_ctrl, ctrl_write);
				repeat (blocks) push_block();
				wait_status(status_in_empty); // DMA drained the input FIFO
				read_reg(reg_wr_addr, value);
				if (value !== exp)
					report_mismatch("WR_ADDR", value, exp);
			end
			op_fill: begin
				write_reg(reg_ctrl, 32'h0);
				repeat (blocks) push_block(); // 48 words, above the 44 limit
				repeat (2) @(posedge okClk);
				if (pipe_in_ready !== 1'b0)
					report_mismatch("pipe_in_ready", word_t'(pipe_in_ready), 32'd0);
				write_reg(reg_ctrl, ctrl_write);
				wait_status(status_in_empty);
				repeat (2) @(posedge okClk);
				if (pipe_in_ready !== 1'b1)
					report_mismatch("pipe_in_ready", word_t'(pipe_in_ready), 32'd1);
				read_reg(reg_wr_addr, value);
				if (value !== exp)
					report_mismatch("WR_ADDR", value, exp);
			end
			op_read: begin
				if (pipe_out_ready !== 1'b0)
					report_mismatch("pipe_out_ready", word_t'(pipe_out_ready), 32'd0);
				write_reg(reg_ctrl, ctrl_read | ctrl_write);
				repeat (blocks) pull_block();
				wait_status(status_out_full); // Prefetch settles with a full FIFO
				read_reg(reg_rd_addr, value);
				if (value !== exp)
					report_mismatch("RD_ADDR", value, exp);
			end
			op_wrap: begin
				repeat (blocks) pull_block();
				wait_status(status_out_full);
				read_reg(reg_rd_addr, value);
				read_reg(reg_wr_addr, other);
				if (value !== exp)
					report_mismatch("RD_ADDR", value, exp);
				if (!(value > other))
					report_problem("RD_ADDR did not move past WR_ADDR");
			end
			op_soft: begin
				write_reg(reg_ctrl, ctrl_soft);
				repeat (4) @(posedge okClk);
				write_reg(reg_ctrl, 32'h0);
				scoreboard.delete();
				check_idle(exp);
			end
			default: report_problem("test table holds an unknown operation");
		endcase
	endtask

	// Watchdog
	initial begin
		cycle_limit = table_limit();
		cycle_count = 0;
		while (cycle_count < cycle_limit) begin
			@(posedge okClk);
			cycle_count++;
		end
		$display("ERROR run stopped after %0d cycles without reaching the end", cycle_count);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		pipe_in_write = 1'b0;
		pipe_in_data = '0;
		pipe_out_read = 1'b0;
		lcg_state = 32'hbf5f_4825;
		error_total = 0;
		tests_passed = 0;
		tests_failed = 0;
		repeat (10) @(posedge okClk);
		rst_n <= 1'b1;
		for (int t = 0; t < n_tests; t++) begin
			test_errors = 0;
			run_test(op_tab[t], blocks_tab[t], expect_tab[t]);
			if (test_errors == 0) begin
				tests_passed++;
				$display("test %0d %s passed", t + 1, op_name(op_tab[t]));
			end else begin
				tests_failed++;
				$display("test %0d %s failed with %0d errors", t + 1, op_name(op_tab[t]),
					test_errors);
			end
			error_total += test_errors;
		end
		$display("summary %0d tests, %0d passed, %0d failed, %0d failed checks",
			n_tests, tests_passed, tests_failed, error_total);
		if (tests_failed == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
